/* flist.f */
+incdir+rtl
+incdir+sim
rtl/ntt_pkg.sv
rtl/mod_mul.sv
rtl/ntt_butterfly.sv
rtl/twiddle_rom.sv
rtl/coeff_mem.sv
rtl/ntt_ctrl.sv
rtl/ntt_top.sv
sim/ntt_tb.sv

/* rtl/coeff_mem.sv */
`include "ntt_cfg.svh"

module coeff_mem
  import ntt_pkg::*;
(
  input  logic        pi_clk,
  input  logic        rd_bank,
  input  coeff_addr_t rd_addr_a,
  input  coeff_addr_t rd_addr_b,
  output coeff_t      rd_data_a,
  output coeff_t      rd_data_b,
  input  logic        wr_bank,
  input  logic [1:0]  wr_en,
  input  coeff_addr_t wr_addr_a,
  input  coeff_addr_t wr_addr_b,
  input  coeff_t      wr_data_a,
  input  coeff_t      wr_data_b
);

  // Two ping-pong banks, one read per round and the other written
  coeff_t bank_mem [2][`NTT_N];

  // Bit 0 of wr_en enables port a, bit 1 port b
  always_ff @(posedge pi_clk) begin
    if (wr_en[0]) begin
      bank_mem[wr_bank][wr_addr_a] <= wr_data_a;
    end
    if (wr_en[1]) begin
      bank_mem[wr_bank][wr_addr_b] <= wr_data_b;
    end
  end

  always_ff @(posedge pi_clk) begin
    rd_data_a <= bank_mem[rd_bank][rd_addr_a];
    rd_data_b <= bank_mem[rd_bank][rd_addr_b];
  end

  a_wr_ports_distinct: assert property (@(posedge pi_clk)
    (&wr_en) |-> (wr_addr_a != wr_addr_b));

endmodule

/* rtl/mod_mul.sv */
`include "ntt_cfg.svh"

module mod_mul
  import ntt_pkg::*;
(
  input  logic   pi_clk,
  input  logic   rst_n,
  input  coeff_t a,
  input  coeff_t b,
  output coeff_t p
);

  // Barrett constant floor(2^46 / q), fits in 24 bits
  localparam logic [23:0] MU = 24'((64'd1 << 46) / `NTT_Q);

  logic [2*`COEFF_W-1:0] prod_q;
  logic [69:0]           est;
  logic [23:0]           qhat;
  logic [2*`COEFF_W-1:0] rem_full;
  logic [24:0]           rem;
  coeff_t                red;

  // Quotient estimate is low by at most two, so the remainder stays below 3q
  always_comb begin
    est      = prod_q * MU;
    qhat     = est[69:46];
    rem_full = prod_q - qhat * `NTT_Q;
    rem      = rem_full[24:0];
    if (rem >= 25'(2 * `NTT_Q)) begin
      red = coeff_t'(rem - 25'(2 * `NTT_Q));
    end else if (rem >= 25'(`NTT_Q)) begin
      red = coeff_t'(rem - 25'(`NTT_Q));
    end else begin
      red = coeff_t'(rem);
    end
  end

  // Stage one forms the full product, stage two registers the reduced value
  always_ff @(posedge pi_clk or negedge rst_n) begin
    if (!rst_n) begin
      prod_q <= '0;
      p      <= '0;
    end else begin
      prod_q <= a * b;
      p      <= red;
    end
  end

endmodule

/* rtl/ntt_butterfly.sv */
`include "ntt_cfg.svh"

module ntt_butterfly
  import ntt_pkg::*;
(
  input  logic    pi_clk,
  input  logic    rst_n,
  input  logic    req_valid,
  input  bf_req_t req,
  output logic    rsp_valid,
  output bf_rsp_t rsp
);

  coeff_t                 wb;
  coeff_t                 a_d1;
  coeff_t                 a_d2;
  coeff_addr_t            ia_d1;
  coeff_addr_t            ia_d2;
  coeff_addr_t            ib_d1;
  coeff_addr_t            ib_d2;
  logic [`BF_LATENCY-1:0] vld_sr;
  logic [`COEFF_W:0]      sum;
  coeff_t                 sum_mod;
  coeff_t                 diff_mod;

  mod_mul i_mod_mul (
    .pi_clk (pi_clk),
    .rst_n  (rst_n),
    .a      (req.w),
    .b      (req.b),
    .p      (wb)
  );

  // Operand a and the slots ride along with the two multiplier stages
  always_ff @(posedge pi_clk) begin
    a_d1  <= req.a;
    ia_d1 <= req.idx_a;
    ib_d1 <= req.idx_b;
    a_d2  <= a_d1;
    ia_d2 <= ia_d1;
    ib_d2 <= ib_d1;
  end

  always_comb begin
    sum     = {1'b0, a_d2} + {1'b0, wb};
    sum_mod = (sum >= (`COEFF_W+1)'(`NTT_Q)) ? coeff_t'(sum - `NTT_Q) : coeff_t'(sum);
    if (a_d2 >= wb) begin
      diff_mod = a_d2 - wb;
    end else begin
      diff_mod = coeff_t'({1'b0, a_d2} + {1'b0, `NTT_Q} - {1'b0, wb});
    end
  end

  // Stage three registers a + wb and a - wb
  always_ff @(posedge pi_clk) begin
    rsp.ra    <= sum_mod;
    rsp.rb    <= diff_mod;
    rsp.idx_a <= ia_d2;
    rsp.idx_b <= ib_d2;
  end

  always_ff @(posedge pi_clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_sr <= '0;
    end else begin
      vld_sr <= {vld_sr[`BF_LATENCY-2:0], req_valid};
    end
  end

  assign rsp_valid = vld_sr[`BF_LATENCY-1];

endmodule

/* rtl/ntt_cfg.svh */
`ifndef NTT_CFG_SVH
`define NTT_CFG_SVH

// Prime modulus q = 2^23 - 2^13 + 1
`define NTT_Q 23'd8380417

// Width of one coefficient
`define COEFF_W 23

// Transform size and number of radix-2 rounds
`define NTT_N 16
`define NTT_LOGN 4

// Primitive 512th root of unity modulo q
`define NTT_ROOT 1753

// Butterfly depth in cycles, request to response
`define BF_LATENCY 3

// Load credits handed out per transform
`define LOAD_CREDITS 16

`endif

/* rtl/ntt_ctrl.sv */
`include "ntt_cfg.svh"

module ntt_ctrl
  import ntt_pkg::*;
(
  input  logic          pi_clk,
  input  logic          rst_n,
  input  logic          start,
  input  logic          load_valid,
  input  logic          unload_credit,
  input  coeff_t        rd_data_a,
  input  coeff_t        rd_data_b,
  input  coeff_t        twiddle,
  input  logic          bf_rsp_valid,
  input  bf_rsp_t       bf_rsp,
  output logic          load_credit,
  output logic          out_valid,
  output logic          busy,
  output logic          done,
  output logic          mem_rd_bank,
  output coeff_addr_t   mem_rd_addr_a,
  output coeff_addr_t   mem_rd_addr_b,
  output logic          mem_wr_bank,
  output logic [1:0]    mem_wr_en,
  output coeff_addr_t   mem_wr_addr_a,
  output coeff_addr_t   mem_wr_addr_b,
  output logic          mem_wr_load,
  output coeff_t        mem_wr_res_a,
  output coeff_t        mem_wr_res_b,
  output twiddle_addr_t twiddle_addr,
  output logic          bf_req_valid,
  output bf_req_t       bf_req
);

  rd_state_e   rd_state;
  wr_state_e   wr_state;
  round_t      round_cnt;
  logic [2:0]  step_cnt;
  logic [2:0]  iss_pair;
  logic [2:0]  wr_cnt;
  coeff_addr_t idx_cnt;
  logic [4:0]  load_sent;
  logic [4:0]  unl_cred;
  logic        load_beat;
  logic        unl_issue;
  logic        last_beat;
  bf_rsp_t     wr_rsp_q;

  // ------------------------------
  // Pair indexing
  // ------------------------------

  // Group of pair p in round r, with half-distance 8 >> r
  function automatic coeff_addr_t pair_grp(input round_t r, input logic [2:0] p);
    return coeff_addr_t'(p) >> (3'd3 - r);
  endfunction

  function automatic coeff_addr_t pair_lo(input round_t r, input logic [2:0] p);
    coeff_addr_t off;
    off = coeff_addr_t'(p) & (4'd7 >> r);
    return (pair_grp(r, p) << (3'd4 - r)) | off;
  endfunction

  function automatic twiddle_addr_t tw_idx(input round_t r, input logic [2:0] p);
    return (4'd1 << r) + pair_grp(r, p);
  endfunction

  // Addresses run one pair ahead of the data because reads are registered
  always_comb begin
    iss_pair      = (rd_state == RD_EXEC) ? step_cnt + 3'd1 : 3'd0;
    mem_rd_bank   = round_cnt[0];
    mem_rd_addr_a = (rd_state == RD_UNLOAD) ? idx_cnt : pair_lo(round_cnt, iss_pair);
    mem_rd_addr_b = pair_lo(round_cnt, iss_pair) + (4'd8 >> round_cnt);
    twiddle_addr  = tw_idx(round_cnt, iss_pair);
  end

  assign bf_req_valid = (rd_state == RD_EXEC);
  assign bf_req.a     = rd_data_a;
  assign bf_req.b     = rd_data_b;
  assign bf_req.w     = twiddle;
  assign bf_req.idx_a = pair_lo(round_cnt, step_cnt);
  assign bf_req.idx_b = pair_lo(round_cnt, step_cnt) + (4'd8 >> round_cnt);

  assign load_beat = (rd_state == RD_LOAD) && load_valid;
  assign unl_issue = (rd_state == RD_UNLOAD) && (unl_cred != 5'd0);
  assign last_beat = unl_issue && (idx_cnt == coeff_addr_t'(`NTT_N - 1));

  // ------------------------------
  // Read FSM
  // ------------------------------
  always_ff @(posedge pi_clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_state  <= RD_IDLE;
      round_cnt <= '0;
      step_cnt  <= '0;
      idx_cnt   <= '0;
    end else begin
      case (rd_state)
        RD_IDLE: begin
          if (start) begin
            rd_state  <= RD_LOAD;
            round_cnt <= '0;
            step_cnt  <= '0;
            idx_cnt   <= '0;
          end
        end
        RD_LOAD: begin
          if (load_beat) begin
            idx_cnt <= idx_cnt + 1'b1;
            if (idx_cnt == coeff_addr_t'(`NTT_N - 1)) begin
              rd_state <= RD_STAGE;
            end
          end
        end
        RD_STAGE: begin
          rd_state <= RD_EXEC;
        end
        RD_EXEC: begin
          step_cnt <= step_cnt + 3'd1;
          if (step_cnt == 3'(`NTT_N / 2 - 1)) begin
            step_cnt <= '0;
            rd_state <= RD_WAIT;
          end
        end
        RD_WAIT: begin
          // Hold until the last response of the round is in memory
          step_cnt <= step_cnt + 3'd1;
          if (step_cnt == 3'(`BF_LATENCY)) begin
            step_cnt  <= '0;
            round_cnt <= round_cnt + 3'd1;
            rd_state  <= (round_cnt == round_t'(`NTT_LOGN - 1)) ? RD_UNLOAD : RD_STAGE;
          end
        end
        RD_UNLOAD: begin
          if (unl_issue) begin
            idx_cnt <= idx_cnt + 1'b1;
            if (last_beat) begin
              rd_state <= RD_IDLE;
            end
          end
        end
        default: rd_state <= RD_IDLE;
      endcase
    end
  end

  // ------------------------------
  // Write FSM
  // ------------------------------
  always_ff @(posedge pi_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_state <= WR_IDLE;
      wr_cnt   <= '0;
    end else begin
      case (wr_state)
        WR_IDLE: begin
          if (rd_state == RD_STAGE) begin
            wr_state <= WR_STAGE;
          end
        end
        WR_STAGE: begin
          if (bf_rsp_valid) begin
            wr_state <= WR_MEM;
            wr_cnt   <= '0;
          end
        end
        WR_MEM: begin
          wr_cnt <= wr_cnt + 3'd1;
          if (wr_cnt == 3'(`NTT_N / 2 - 1)) begin
            wr_state <= WR_IDLE;
          end
        end
        default: wr_state <= WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge pi_clk) begin
    if (bf_rsp_valid) begin
      wr_rsp_q <= bf_rsp;
    end
  end

  // Load beats go to bank 0, round results to the bank not being read
  assign mem_wr_load   = (rd_state == RD_LOAD);
  assign mem_wr_en     = (wr_state == WR_MEM) ? 2'b11 : {1'b0, load_beat};
  assign mem_wr_bank   = mem_wr_load ? 1'b0 : ~round_cnt[0];
  assign mem_wr_addr_a = mem_wr_load ? idx_cnt : wr_rsp_q.idx_a;
  assign mem_wr_addr_b = wr_rsp_q.idx_b;
  assign mem_wr_res_a  = wr_rsp_q.ra;
  assign mem_wr_res_b  = wr_rsp_q.rb;

  // ------------------------------
  // Credits and stream status
  // ------------------------------
  always_ff @(posedge pi_clk or negedge rst_n) begin
    if (!rst_n) begin
      load_credit <= 1'b0;
      load_sent   <= '0;
      unl_cred    <= '0;
      out_valid   <= 1'b0;
      done        <= 1'b0;
      busy        <= 1'b0;
    end else begin
      load_credit <= 1'b0;
      if (rd_state == RD_IDLE && start) begin
        load_sent <= '0;
      end else if (rd_state == RD_LOAD && load_sent < 5'(`LOAD_CREDITS)) begin
        load_credit <= 1'b1;
        load_sent   <= load_sent + 5'd1;
      end
      unl_cred  <= unl_cred + 5'(unload_credit) - 5'(unl_issue);
      out_valid <= unl_issue;
      done      <= last_beat;
      if (rd_state == RD_IDLE && start) begin
        busy <= 1'b1;
      end else if (last_beat) begin
        busy <= 1'b0;
      end
    end
  end

  a_busy_state: assert property (@(posedge pi_clk) disable iff (!rst_n)
    busy == (rd_state != RD_IDLE));

  a_done_last: assert property (@(posedge pi_clk) disable iff (!rst_n)
    done |-> out_valid && (round_cnt == round_t'(`NTT_LOGN)) &&
             $past(idx_cnt == coeff_addr_t'(`NTT_N - 1)));

  // Credits in hand never pass one transform's worth so the 5-bit count cannot wrap
  a_out_credit: assert property (@(posedge pi_clk) disable iff (!rst_n)
    unl_cred <= 5'(`NTT_N));

  // Every request returns after the butterfly depth
  a_bf_req: assert property (@(posedge pi_clk) disable iff (!rst_n)
    bf_req_valid |-> ##`BF_LATENCY bf_rsp_valid);

  // The group of a pair is its low index over the block size 16 >> r
  a_twiddle: assert property (@(posedge pi_clk) disable iff (!rst_n)
    bf_req_valid |->
      $past(twiddle_addr) == (4'd1 << round_cnt) + (bf_req.idx_a >> (3'd4 - round_cnt)));

  // Round results land only while the round still runs and in the bank not being read
  a_bank_split: assert property (@(posedge pi_clk) disable iff (!rst_n)
    ((|mem_wr_en) && !mem_wr_load) |->
      (rd_state inside {RD_EXEC, RD_WAIT}) && (mem_wr_bank != mem_rd_bank));

endmodule

/* rtl/ntt_pkg.sv */
`include "ntt_cfg.svh"

package ntt_pkg;

  typedef logic [`COEFF_W-1:0] coeff_t;
  typedef logic [$clog2(`NTT_N)-1:0] coeff_addr_t;
  typedef logic [2:0] round_t;
  typedef logic [3:0] twiddle_addr_t;

  // One butterfly operand pair with its twiddle and destination slots
  typedef struct packed {
    coeff_t      a;
    coeff_t      b;
    coeff_t      w;
    coeff_addr_t idx_a;
    coeff_addr_t idx_b;
  } bf_req_t;

  typedef struct packed {
    coeff_t      ra;
    coeff_t      rb;
    coeff_addr_t idx_a;
    coeff_addr_t idx_b;
  } bf_rsp_t;

  typedef enum logic [2:0] {
    RD_IDLE, RD_LOAD, RD_STAGE, RD_EXEC, RD_WAIT, RD_UNLOAD
  } rd_state_e;

  typedef enum logic [1:0] {
    WR_IDLE, WR_STAGE, WR_MEM
  } wr_state_e;

  function automatic longint unsigned mod_exp(input longint unsigned base,
                                              input int unsigned exp);
    longint unsigned acc;
    acc = 1;
    for (int unsigned i = 0; i < exp; i++) begin
      acc = (acc * base) % `NTT_Q;
    end
    return acc;
  endfunction

  // Power of the 32nd root indexed by the bit-reversed 4-bit value of k
  function automatic coeff_t zeta_table(input int unsigned k);
    longint unsigned psi;
    int unsigned     brv;
    psi = mod_exp(`NTT_ROOT, 16);
    brv = {28'd0, k[0], k[1], k[2], k[3]};
    return coeff_t'(mod_exp(psi, brv));
  endfunction

endpackage

/* rtl/ntt_top.sv */
module ntt_top
  import ntt_pkg::*;
(
  input  logic   pi_clk,
  input  logic   rst_n,
  input  logic   start,
  input  logic   load_valid,
  input  coeff_t load_data,
  output logic   load_credit,
  input  logic   unload_credit,
  output logic   out_valid,
  output coeff_t out_data,
  output logic   busy,
  output logic   done
);

  logic          rd_bank;
  coeff_addr_t   rd_addr_a;
  coeff_addr_t   rd_addr_b;
  coeff_t        rd_data_a;
  coeff_t        rd_data_b;
  logic          wr_bank;
  logic [1:0]    wr_en;
  coeff_addr_t   wr_addr_a;
  coeff_addr_t   wr_addr_b;
  logic          wr_load;
  coeff_t        wr_res_a;
  coeff_t        wr_res_b;
  coeff_t        wr_data_a;
  twiddle_addr_t tw_addr;
  coeff_t        tw;
  logic          bf_req_valid;
  bf_req_t       bf_req;
  logic          bf_rsp_valid;
  bf_rsp_t       bf_rsp;

  // Port a takes stream data during load and butterfly results otherwise
  assign wr_data_a = wr_load ? load_data : wr_res_a;

  // Unload reads come back on port a
  assign out_data = rd_data_a;

  ntt_ctrl i_ctrl (
    .pi_clk        (pi_clk),
    .rst_n         (rst_n),
    .start         (start),
    .load_valid    (load_valid),
    .unload_credit (unload_credit),
    .rd_data_a     (rd_data_a),
    .rd_data_b     (rd_data_b),
    .twiddle       (tw),
    .bf_rsp_valid  (bf_rsp_valid),
    .bf_rsp        (bf_rsp),
    .load_credit   (load_credit),
    .out_valid     (out_valid),
    .busy          (busy),
    .done          (done),
    .mem_rd_bank   (rd_bank),
    .mem_rd_addr_a (rd_addr_a),
    .mem_rd_addr_b (rd_addr_b),
    .mem_wr_bank   (wr_bank),
    .mem_wr_en     (wr_en),
    .mem_wr_addr_a (wr_addr_a),
    .mem_wr_addr_b (wr_addr_b),
    .mem_wr_load   (wr_load),
    .mem_wr_res_a  (wr_res_a),
    .mem_wr_res_b  (wr_res_b),
    .twiddle_addr  (tw_addr),
    .bf_req_valid  (bf_req_valid),
    .bf_req        (bf_req)
  );

  coeff_mem i_mem (
    .pi_clk    (pi_clk),
    .rd_bank   (rd_bank),
    .rd_addr_a (rd_addr_a),
    .rd_addr_b (rd_addr_b),
    .rd_data_a (rd_data_a),
    .rd_data_b (rd_data_b),
    .wr_bank   (wr_bank),
    .wr_en     (wr_en),
    .wr_addr_a (wr_addr_a),
    .wr_addr_b (wr_addr_b),
    .wr_data_a (wr_data_a),
    .wr_data_b (wr_res_b)
  );

  twiddle_rom i_rom (
    .pi_clk (pi_clk),
    .addr   (tw_addr),
    .w      (tw)
  );

  ntt_butterfly i_bf (
    .pi_clk    (pi_clk),
    .rst_n     (rst_n),
    .req_valid (bf_req_valid),
    .req       (bf_req),
    .rsp_valid (bf_rsp_valid),
    .rsp       (bf_rsp)
  );

endmodule

/* rtl/twiddle_rom.sv */
`include "ntt_cfg.svh"

module twiddle_rom
  import ntt_pkg::*;
(
  input  logic          pi_clk,
  input  twiddle_addr_t addr,
  output coeff_t        w
);

  coeff_t rom [`NTT_N];

  // Table contents are constants worked out during elaboration
  for (genvar i = 0; i < `NTT_N; i++) begin : g_rom
    localparam coeff_t ZETA = zeta_table(i);
    assign rom[i] = ZETA;
  end

  always_ff @(posedge pi_clk) begin
    w <= rom[addr];
  end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build the NTT testbench with Verilator, run it and scan the log.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f flist.f \
  --top-module ntt_tb \
  -Mdir obj_dir \
  -o ntt_sim

# The pipe keeps a nonzero exit of the simulator from ending the script here
./obj_dir/ntt_sim 2>&1 | tee sim.log

if grep -q "Simulation failed" sim.log; then
  echo "Result: FAIL"
  exit 1
fi

if ! grep -q "Simulation passed" sim.log; then
  echo "Result: FAIL (run ended without a result)"
  exit 1
fi

echo "Result: PASS"

/* sim/ntt_ref.svh */
`ifndef NTT_REF_SVH
`define NTT_REF_SVH

// Reference model for the forward negacyclic transform.
// Output k is the input polynomial evaluated at psi^(2*brv(k)+1), where
// psi is the 32nd root of unity taken as NTT_ROOT^16 modulo q

// Square and multiply, a^e modulo q
function automatic longint unsigned pow_mod(input longint unsigned a, input int unsigned e);
  longint unsigned result;
  longint unsigned sq;
  int unsigned     k;
  result = 1;
  sq     = a % `NTT_Q;
  k      = e;
  while (k != 0) begin
    if (k[0]) begin
      result = (result * sq) % `NTT_Q;
    end
    sq = (sq * sq) % `NTT_Q;
    k  = k >> 1;
  end
  return result;
endfunction

// Reverse the low four bits of v
function automatic int unsigned rev4(input int unsigned v);
  int unsigned r;
  int          i;
  r = 0;
  for (i = 0; i < 4; i++) begin
    if (v[i]) begin
      r = r | (1 << (3 - i));
    end
  end
  return r;
endfunction

// Horner evaluation of c(x) modulo q
function automatic longint unsigned poly_at(input longint unsigned c [`NTT_N],
                                            input longint unsigned x);
  longint unsigned acc;
  int              i;
  acc = 0;
  for (i = `NTT_N - 1; i >= 0; i--) begin
    acc = (acc * x + c[i]) % `NTT_Q;
  end
  return acc;
endfunction

function automatic longint unsigned expected_out(input longint unsigned c [`NTT_N],
                                                 input int unsigned k);
  longint unsigned psi;
  psi = pow_mod(`NTT_ROOT, 16);
  return poly_at(c, pow_mod(psi, 2 * rev4(k) + 1));
endfunction

`endif

/* sim/ntt_tb.sv */
`include "ntt_cfg.svh"

module ntt_tb
  import ntt_pkg::*;
();

  localparam int MAX_TF        = 8;
  localparam int LOAD_WAIT_MAX = 200;
  localparam int DONE_WAIT_MAX = 3000;

  logic   pi_clk;
  logic   rst_n;
  logic   start;
  logic   load_valid;
  coeff_t load_data;
  logic   load_credit;
  logic   unload_credit;
  logic   out_valid;
  coeff_t out_data;
  logic   busy;
  logic   done;

  bit              started;
  int              tf_started;
  int              max_gap;
  int              credits_sent;
  int              out_total;
  int              cred_total;
  int              done_total;
  int              starts_taken;
  int              lc_cnt;
  longint unsigned exp_all [MAX_TF*`NTT_N];

  `include "ntt_ref.svh"

  ntt_top i_dut (
    .pi_clk        (pi_clk),
    .rst_n         (rst_n),
    .start         (start),
    .load_valid    (load_valid),
    .load_data     (load_data),
    .load_credit   (load_credit),
    .unload_credit (unload_credit),
    .out_valid     (out_valid),
    .out_data      (out_data),
    .busy          (busy),
    .done          (done)
  );

  initial begin
    pi_clk = 1'b0;
    forever #4 pi_clk = ~pi_clk;
  end

  task automatic fail_with(input string what);
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic value_error(input string name, input longint unsigned got,
                             input longint unsigned want);
    fail_with($sformatf("error at time %0t: %s is %0d, expected %0d",
                        $time, name, got, want));
  endtask

  // ------------------------------
  // Event counters
  // ------------------------------
  always @(posedge pi_clk or negedge rst_n) begin
    if (!rst_n) begin
      out_total    <= 0;
      cred_total   <= 0;
      done_total   <= 0;
      starts_taken <= 0;
      lc_cnt       <= 0;
    end else begin
      if (out_valid) out_total <= out_total + 1;
      if (unload_credit) cred_total <= cred_total + 1;
      if (done) done_total <= done_total + 1;
      // A start seen while idle opens a new transform
      if (start && !busy) begin
        starts_taken <= starts_taken + 1;
        lc_cnt       <= 0;
      end else if (load_credit) begin
        lc_cnt <= lc_cnt + 1;
      end
    end
  end

  // ------------------------------
  // Checks
  // ------------------------------
  a_idle_quiet: assert property (@(posedge pi_clk) disable iff (!rst_n)
    !started |-> !(busy || done || out_valid || load_credit))
    else value_error("{busy,done,out_valid,load_credit}",
                     $sampled({busy, done, out_valid, load_credit}), 0);

  a_out_data: assert property (@(posedge pi_clk) disable iff (!rst_n)
    out_valid |-> out_data == coeff_t'(exp_all[out_total]))
    else value_error("out_data", $sampled(out_data), exp_all[$sampled(out_total)]);

  a_out_credit: assert property (@(posedge pi_clk) disable iff (!rst_n)
    out_valid |-> out_total < cred_total)
    else fail_with("out_valid was sent without an unload credit in hand");

  a_load_credits: assert property (@(posedge pi_clk) disable iff (!rst_n)
    load_credit |-> lc_cnt < `LOAD_CREDITS)
    else fail_with("More than 16 load credits were returned in one transform");

  a_done_pulse: assert property (@(posedge pi_clk) disable iff (!rst_n)
    done |=> !done)
    else fail_with("done stayed high for more than one cycle");

  a_done_busy: assert property (@(posedge pi_clk) disable iff (!rst_n)
    done |-> !busy)
    else fail_with("busy was still high when done pulsed");

  a_busy_fall: assert property (@(posedge pi_clk) disable iff (!rst_n)
    $fell(busy) |-> done)
    else fail_with("busy fell without a done pulse");

  a_busy_rise: assert property (@(posedge pi_clk) disable iff (!rst_n)
    (start && !busy) |=> busy)
    else fail_with("busy did not rise the cycle after start");

  // ------------------------------
  // Unload sink with random credit gaps
  // ------------------------------
  initial begin : unload_sink
    int gap;
    unload_credit = 1'b0;
    credits_sent  = 0;
    gap           = 0;
    forever begin
      @(negedge pi_clk);
      unload_credit = 1'b0;
      if (rst_n && credits_sent < tf_started * `NTT_N) begin
        if (gap == 0) begin
          unload_credit = 1'b1;
          credits_sent  = credits_sent + 1;
          gap           = $urandom_range(max_gap, 0);
        end else begin
          gap = gap - 1;
        end
      end
    end
  end

  // One full transform, entered and left on a falling edge
  task automatic run_transform(input longint unsigned c [`NTT_N], input bit poke_busy);
    int held;
    int sent;
    int cycles;
    int k;
    int out_base;
    int done_base;
    if (tf_started >= MAX_TF) begin
      fail_with("Too many transforms for the expected-value table");
    end
    for (k = 0; k < `NTT_N; k++) begin
      exp_all[tf_started*`NTT_N + k] = expected_out(c, k);
    end
    out_base   = out_total;
    done_base  = done_total;
    start      = 1'b1;
    started    = 1'b1;
    tf_started = tf_started + 1;
    @(negedge pi_clk);
    start  = 1'b0;
    held   = 0;
    sent   = 0;
    cycles = 0;
    // Send only while a credit is held, with the odd idle beat
    while (sent < `NTT_N) begin
      if (load_credit) held = held + 1;
      if (held > 0 && ($urandom % 4) != 0) begin
        load_valid = 1'b1;
        load_data  = coeff_t'(c[sent]);
        held       = held - 1;
        sent       = sent + 1;
      end else begin
        load_valid = 1'b0;
      end
      @(negedge pi_clk);
      cycles = cycles + 1;
      if (cycles > LOAD_WAIT_MAX) begin
        fail_with("Timeout while waiting for load credits");
      end
    end
    load_valid = 1'b0;
    cycles     = 0;
    while (!done) begin
      @(negedge pi_clk);
      cycles = cycles + 1;
      start  = poke_busy && (cycles == 20);
      if (cycles > DONE_WAIT_MAX) begin
        fail_with("Timeout while waiting for done");
      end
    end
    start = 1'b0;
    // The last beat and done are counted on the next rising edge
    @(negedge pi_clk);
    assert (out_total - out_base == `NTT_N)
      else value_error("out_valid beat count", out_total - out_base, `NTT_N);
    assert (done_total - done_base == 1)
      else value_error("done pulse count", done_total - done_base, 1);
    assert (starts_taken == tf_started)
      else value_error("accepted start count", starts_taken, tf_started);
  endtask

  // ------------------------------
  // Stimulus
  // ------------------------------
  initial begin : stimulus
    longint unsigned poly [`NTT_N];
    int              t;
    int              k;
    void'($urandom(92157));
    rst_n      = 1'b0;
    start      = 1'b0;
    load_valid = 1'b0;
    load_data  = '0;
    started    = 1'b0;
    tf_started = 0;
    max_gap    = 2;
    repeat (10) @(negedge pi_clk);
    rst_n = 1'b1;
    // Stay idle for a while so the quiet-output check gets exercised
    repeat (6) @(negedge pi_clk);

    // Delta input transforms to all ones
    for (k = 0; k < `NTT_N; k++) begin
      poly[k] = (k == 0) ? 1 : 0;
    end
    run_transform(poly, 1'b0);

    for (t = 0; t < 3; t++) begin
      for (k = 0; k < `NTT_N; k++) begin
        poly[k] = $urandom % `NTT_Q;
      end
      run_transform(poly, 1'b0);
    end

    // Sparse unload credits throttle the output stream
    max_gap = 14;
    for (k = 0; k < `NTT_N; k++) begin
      poly[k] = $urandom % `NTT_Q;
    end
    run_transform(poly, 1'b0);

    // A second start lands in the middle of the rounds
    max_gap = 3;
    for (k = 0; k < `NTT_N; k++) begin
      poly[k] = $urandom % `NTT_Q;
    end
    run_transform(poly, 1'b1);
    for (k = 0; k < 10; k++) begin
      @(negedge pi_clk);
      assert (!busy)
        else fail_with("A start pulsed while busy launched another transform");
    end

    $display("Simulation passed");
    $finish;
  end

endmodule
